//--- sources.f
hw/fighterPkg.sv
hw/keyDecoder.sv
hw/jumpControl.sv
hw/fighterMotion.sv
hw/combatSpacing.sv
hw/arenaTop.sv
testbench/arenaTb.sv

//--- run.sh
#!/bin/sh
# Build with Verilator, run, and decide on the pass line in the output
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module arenaTb \
    -f sources.f -Mdir obj_dir \
    && ./obj_dir/VarenaTb | tee /dev/stderr | grep -q "RESULT: PASS" \
    && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }

//--- testbench/arenaTb.sv
`timescale 1ns/1ps

module arenaTb;
    import fighterPkg::*;

    localparam int ClkPeriod = 8;
    localparam int ResetCycles = 8;
    localparam int DirectedFrames = 397;    // Sum of the directed phase lengths below
    localparam int RandomFrames = 300;
    localparam int P1Start = 40;
    localparam int P2Start = 400;
    localparam int BoundMin = 10;
    localparam int BoundMax = 600;
    localparam int MinGap = 105;
    localparam int HitReach = 130;
    localparam int KnockStep = 3;
    localparam int JumpSpeed = 12;
    localparam int FloorY = 215;

    localparam logic [7:0] KeyA = 8'h04;
    localparam logic [7:0] KeyD = 8'h07;
    localparam logic [7:0] KeyS = 8'h16;
    localparam logic [7:0] KeyW = 8'h1A;
    localparam logic [7:0] KeyF = 8'h09;
    localparam logic [7:0] KeyLeft = 8'h50;
    localparam logic [7:0] KeyRight = 8'h4F;
    localparam logic [7:0] KeyDown = 8'h51;
    localparam logic [7:0] KeyUp = 8'h52;
    localparam logic [7:0] KeyM = 8'h10;

    logic Reset;                    // Clock port of the design
    logic frame_clk;                // Reset port of the design
    logic playing;
    logic [7:0] keys [4];
    fighterState_t p1State;
    fighterState_t p2State;

    fighterState_t mP1;             // Reference model state
    fighterState_t mP2;
    int mVel1;
    int mVel2;
    int seed = 70;
    int airFrames;
    logic [7:0] keyPool [11];

    arenaTop u_dut (
        .Reset     (Reset),
        .frame_clk (frame_clk),
        .playing   (playing),
        .keys      (keys),
        .p1State   (p1State),
        .p2State   (p2State)
    );

    always #(ClkPeriod / 2) Reset = ~Reset;

    task automatic reportMismatch(input string name, input logic [24:0] expected,
                                  input logic [24:0] actual);
        $display("Fail at %0t ns: %s expected %h, actual %h", $time, name, expected, actual);
        $display("RESULT: FAIL");
        $fatal(1, "Mismatch on %s", name);
    endtask

    task automatic stopWithError(input string what);
        $display("%s", what);
        $display("RESULT: FAIL");
        $fatal(1, "%s", what);
    endtask

    function automatic fighterState_t restState(input int x);
        fighterState_t s;
        s = '0;
        s.xPos = coord_t'(x);
        s.yPos = coord_t'(FloorY);
        return s;
    endfunction

    function automatic logic keyHeld(input logic [7:0] code);
        return (keys[0] == code) || (keys[1] == code) || (keys[2] == code) || (keys[3] == code);
    endfunction

    function automatic fighterState_t stepFighter(input fighterState_t cur, input int vel,
                                                  input fighterAction_t act, input int gapNow,
                                                  input int knock, input logic facesLeft);
        fighterState_t nxt;
        int x;
        int y;
        int walk;
        logic leftOk;
        logic rightOk;
        logic landing;
        x = int'(cur.xPos);
        y = int'(cur.yPos);
        leftOk = facesLeft ? (gapNow > MinGap) : (x - 2 >= BoundMin);
        rightOk = facesLeft ? (x + 2 <= BoundMax) : (gapNow > MinGap);
        walk = 0;
        if (!act.crouch && !(act.walkLeft && act.walkRight))
        begin
            if (act.walkLeft && leftOk)
                walk = -2;
            else if (act.walkRight && rightOk)
                walk = 2;
        end
        x = x + walk + (facesLeft ? knock : -knock);   // Pushed away from the opponent
        if (x < BoundMin)
            x = BoundMin;
        else if (x > BoundMax)
            x = BoundMax;
        landing = cur.airborne && (y + vel >= FloorY);
        if (landing)
            y = FloorY;
        else if (cur.airborne)
            y = y + vel;
        nxt = cur;
        nxt.xPos = coord_t'(x);
        nxt.yPos = coord_t'(y);
        nxt.airborne = cur.airborne ? !landing : act.jump;
        nxt.crouching = act.crouch;
        nxt.facingLeft = facesLeft;
        nxt.movingLeft = walk < 0;
        nxt.movingRight = walk > 0;
        return nxt;
    endfunction

    function automatic int stepVelocity(input fighterState_t cur, input int vel, input logic jump);
        int nv;
        if (!cur.airborne)
            nv = jump ? -JumpSpeed : 0;
        else if (int'(cur.yPos) + vel >= FloorY)
            nv = 0;                                     // Landed
        else
            nv = vel + 1;                               // Gravity
        return nv;
    endfunction

    always @(posedge Reset or posedge frame_clk)
    begin : referenceModel
        int gapNow;
        int knock1;
        int knock2;
        fighterAction_t a1;
        fighterAction_t a2;
        if (frame_clk)
        begin
            mP1 <= restState(P1Start);
            mP2 <= restState(P2Start);
            mVel1 <= 0;
            mVel2 <= 0;
        end
        else if (playing)
        begin
            a1 = '{keyHeld(KeyA), keyHeld(KeyD), keyHeld(KeyS), keyHeld(KeyW), keyHeld(KeyF)};
            a2 = '{keyHeld(KeyLeft), keyHeld(KeyRight), keyHeld(KeyDown), keyHeld(KeyUp),
                   keyHeld(KeyM)};
            gapNow = int'(mP2.xPos) - int'(mP1.xPos);
            knock1 = (a2.punch && gapNow <= HitReach) ? KnockStep : 0;
            knock2 = (a1.punch && gapNow <= HitReach) ? KnockStep : 0;
            mP1 <= stepFighter(mP1, mVel1, a1, gapNow, knock1, 1'b0);
            mP2 <= stepFighter(mP2, mVel2, a2, gapNow, knock2, 1'b1);
            mVel1 <= stepVelocity(mP1, mVel1, a1.jump);
            mVel2 <= stepVelocity(mP2, mVel2, a2.jump);
        end
    end

    // Compared on the falling edge, both sides settled by then
    p1Check: assert property (@(negedge Reset) disable iff (frame_clk) p1State == mP1)
        else reportMismatch("p1State", mP1, p1State);
    p2Check: assert property (@(negedge Reset) disable iff (frame_clk) p2State == mP2)
        else reportMismatch("p2State", mP2, p2State);
    floorCheck: assert property (@(negedge Reset) disable iff (frame_clk)
                                 int'(p1State.yPos) <= FloorY && int'(p2State.yPos) <= FloorY)
        else stopWithError("A fighter went below the floor line");

    task automatic applyFrame(input logic [7:0] k0, input logic [7:0] k1, input logic [7:0] k2,
                              input logic [7:0] k3, input logic play);
        @(posedge Reset);
        #1;
        keys[0] = k0;
        keys[1] = k1;
        keys[2] = k2;
        keys[3] = k3;
        playing = play;
    endtask

    task automatic holdKeys(input int frames, input logic [7:0] k0, input logic [7:0] k1);
        repeat (frames) applyFrame(k0, k1, 8'h00, 8'h00, 1'b1);
    endtask

    function automatic logic [7:0] randomKey();
        int idx;
        idx = int'($unsigned($random(seed)) % 11);
        return keyPool[idx];
    endfunction

    initial
    begin : watchdog
        #((ResetCycles + DirectedFrames + RandomFrames + 50) * ClkPeriod);
        stopWithError("Watchdog expired, the test did not reach its end");
    end

    initial
    begin
        keyPool = '{8'h00, KeyA, KeyD, KeyS, KeyW, KeyF, KeyLeft, KeyRight, KeyDown, KeyUp, KeyM};
        Reset = 1'b0;
        frame_clk = 1'b1;
        playing = 1'b0;
        keys = '{8'h00, 8'h00, 8'h00, 8'h00};
        repeat (ResetCycles) @(posedge Reset);
        #1;
        frame_clk = 1'b0;
        startP1: assert (p1State == restState(P1Start))
            else reportMismatch("p1State after reset", restState(P1Start), p1State);
        startP2: assert (p2State == restState(P2Start))
            else reportMismatch("p2State after reset", restState(P2Start), p2State);

        holdKeys(2, 8'h00, 8'h00);
        holdKeys(20, KeyA, 8'h00);          // Walks into the left edge
        holdKeys(160, KeyD, 8'h00);         // Walks up to the minimum gap
        holdKeys(5, KeyS, KeyA);            // Crouch cancels walking
        holdKeys(5, KeyA, KeyD);            // Opposing keys cancel

        holdKeys(1, KeyW, 8'h00);
        airFrames = 0;
        repeat (40)
        begin
            applyFrame(8'h00, 8'h00, 8'h00, 8'h00, 1'b1);
            if (p1State.airborne)
                airFrames++;
        end
        jumpLength: assert (airFrames == 2 * JumpSpeed + 1)
            else reportMismatch("p1 airborne frames", 25'(2 * JumpSpeed + 1), 25'(airFrames));

        holdKeys(3, KeyF, 8'h00);           // Player 1 punches within reach
        holdKeys(3, KeyM, 8'h00);
        holdKeys(110, KeyD, KeyRight);      // Player 2 reaches the right edge
        holdKeys(5, KeyF, 8'h00);           // Pushback clamped at the edge
        holdKeys(20, KeyA, 8'h00);
        holdKeys(3, KeyF, 8'h00);           // Out of reach now
        repeat (20) applyFrame(randomKey(), randomKey(), randomKey(), randomKey(), 1'b0);

        for (int i = 0; i < RandomFrames; i++)
            applyFrame(randomKey(), randomKey(), randomKey(), randomKey(),
                       ($random(seed) & 7) != 0);
        applyFrame(8'h00, 8'h00, 8'h00, 8'h00, 1'b0);
        applyFrame(8'h00, 8'h00, 8'h00, 8'h00, 1'b0);
        $display("RESULT: PASS");
        $finish;
    end

endmodule

//--- hw/arenaTop.sv
`timescale 1ns/1ps

module arenaTop #(
    parameter int P1StartX    = 40,
    parameter int P2StartX    = 400,
    parameter int BoundMin    = 10,
    parameter int BoundMax    = 600,
    parameter int MinGap      = 105,
    parameter int HitReach    = 130,
    parameter int KnockStep   = 3,
    parameter int JumpSpeed   = 12,
    parameter bit P1FacesLeft = 1'b0,
    parameter bit P2FacesLeft = 1'b1
) (
    input  logic                      Reset,
    input  logic                      frame_clk,
    input  logic                      playing,
    input  logic [7:0]                keys [4],
    output fighterPkg::fighterState_t p1State,
    output fighterPkg::fighterState_t p2State
);
    import fighterPkg::*;

    fighterAction_t     p1Action;
    fighterAction_t     p2Action;
    logic signed [10:0] gap;
    coord_t             p1Knockback;
    coord_t             p2Knockback;

    // Both players read the same keyboard report
    keyDecoder #(
        .keyMap (P1Keys)
    ) u_p1Decoder (
        .keys   (keys),
        .action (p1Action)
    );

    keyDecoder #(
        .keyMap (P2Keys)
    ) u_p2Decoder (
        .keys   (keys),
        .action (p2Action)
    );

    combatSpacing #(
        .HitReach  (HitReach),
        .KnockStep (KnockStep)
    ) u_spacing (
        .p1State     (p1State),
        .p2State     (p2State),
        .p1Action    (p1Action),
        .p2Action    (p2Action),
        .gap         (gap),
        .p1Knockback (p1Knockback),
        .p2Knockback (p2Knockback)
    );

    fighterMotion #(
        .StartX    (P1StartX),
        .BoundMin  (BoundMin),
        .BoundMax  (BoundMax),
        .MinGap    (MinGap),
        .JumpSpeed (JumpSpeed),
        .FacesLeft (P1FacesLeft)
    ) u_p1Motion (
        .Reset     (Reset),
        .frame_clk (frame_clk),
        .playing   (playing),
        .action    (p1Action),
        .gap       (gap),
        .knockback (p1Knockback),
        .state     (p1State)
    );

    fighterMotion #(
        .StartX    (P2StartX),
        .BoundMin  (BoundMin),
        .BoundMax  (BoundMax),
        .MinGap    (MinGap),
        .JumpSpeed (JumpSpeed),
        .FacesLeft (P2FacesLeft)
    ) u_p2Motion (
        .Reset     (Reset),
        .frame_clk (frame_clk),
        .playing   (playing),
        .action    (p2Action),
        .gap       (gap),
        .knockback (p2Knockback),
        .state     (p2State)
    );

endmodule

//--- hw/combatSpacing.sv
`timescale 1ns/1ps

module combatSpacing #(
    parameter int HitReach  = 130,
    parameter int KnockStep = 3
) (
    input  fighterPkg::fighterState_t  p1State,
    input  fighterPkg::fighterState_t  p2State,
    input  fighterPkg::fighterAction_t p1Action,
    input  fighterPkg::fighterAction_t p2Action,
    output logic signed [10:0]         gap,
    output fighterPkg::coord_t         p1Knockback,
    output fighterPkg::coord_t         p2Knockback
);
    import fighterPkg::*;

    localparam coord_t Push = coord_t'(KnockStep);

    logic signed [10:0] p1Wide;
    logic signed [10:0] p2Wide;
    logic               inReach;
    logic               p1Hit;     // Player 1 is struck this frame
    logic               p2Hit;

    // Player 2 stands to the right, so the gap is normally positive
    assign p1Wide = $signed({1'b0, p1State.xPos});
    assign p2Wide = $signed({1'b0, p2State.xPos});
    assign gap    = p2Wide - p1Wide;

    assign inReach = gap <= HitReach;

    // Crouching gives no cover
    assign p1Hit = p2Action.punch && inReach;
    assign p2Hit = p1Action.punch && inReach;

    assign p1Knockback = p1Hit ? Push : '0;
    assign p2Knockback = p2Hit ? Push : '0;

endmodule

//--- hw/fighterMotion.sv
`timescale 1ns/1ps

module fighterMotion #(
    parameter int StartX    = 40,
    parameter int BoundMin  = 10,
    parameter int BoundMax  = 600,
    parameter int MinGap    = 105,
    parameter int JumpSpeed = 12,
    parameter bit FacesLeft = 1'b0
) (
    input  logic                       Reset,
    input  logic                       frame_clk,
    input  logic                       playing,
    input  fighterPkg::fighterAction_t action,
    input  logic signed [10:0]         gap,
    input  fighterPkg::coord_t         knockback,
    output fighterPkg::fighterState_t  state
);
    import fighterPkg::*;

    localparam logic signed [11:0] WalkStep = 12'sd2;
    localparam logic signed [11:0] LowEdge  = 12'(BoundMin);
    localparam logic signed [11:0] HighEdge = 12'(BoundMax);
    localparam coord_t             MinX     = coord_t'(BoundMin);
    localparam coord_t             MaxX     = coord_t'(BoundMax);

    coord_t            xPos;
    coord_t            yPos;
    logic              crouching;
    logic              facingLeft;
    logic              movingLeft;
    logic              movingRight;
    logic              airborne;
    logic signed [7:0] yMotion;

    logic signed [11:0] xWide;
    logic signed [11:0] push;
    logic signed [11:0] walkMove;
    logic signed [11:0] xTarget;
    logic signed [11:0] yTarget;
    logic               leftOk;
    logic               rightOk;
    coord_t             xNext;

    assign xWide = {2'b00, xPos};
    assign push  = {2'b00, knockback};

    // Stage edge behind the fighter, opponent in front
    always_comb
    begin
        if (FacesLeft)
        begin
            leftOk  = gap > MinGap;
            rightOk = (xWide + WalkStep) <= HighEdge;
        end
        else
        begin
            leftOk  = (xWide - WalkStep) >= LowEdge;
            rightOk = gap > MinGap;
        end
    end

    always_comb
    begin
        walkMove = '0;
        if (!action.crouch && !(action.walkLeft && action.walkRight)) // Crouch or both keys stall
        begin
            if (action.walkLeft && leftOk)
                walkMove = -WalkStep;
            else if (action.walkRight && rightOk)
                walkMove = WalkStep;
        end
    end

    // Knockback always points away from the opponent
    assign xTarget = FacesLeft ? (xWide + walkMove + push) : (xWide + walkMove - push);

    always_comb
    begin
        if (xTarget < LowEdge)
            xNext = MinX;
        else if (xTarget > HighEdge)
            xNext = MaxX;
        else
            xNext = coord_t'(xTarget);
    end

    assign yTarget = $signed({2'b00, yPos}) + yMotion;

    jumpControl #(
        .JumpSpeed (JumpSpeed)
    ) u_jump (
        .Reset     (Reset),
        .frame_clk (frame_clk),
        .playing   (playing),
        .jump      (action.jump),
        .yPos      (yPos),
        .yMotion   (yMotion),
        .airborne  (airborne)
    );

    always_ff @(posedge Reset or posedge frame_clk)
    begin
        if (frame_clk)
        begin
            xPos        <= coord_t'(StartX);
            yPos        <= GroundY;
            crouching   <= 1'b0;
            facingLeft  <= 1'b0;
            movingLeft  <= 1'b0;
            movingRight <= 1'b0;
        end
        else if (playing)
        begin
            xPos        <= xNext;
            yPos        <= coord_t'(yTarget);
            crouching   <= action.crouch;   // Also while in the air
            facingLeft  <= FacesLeft;
            movingLeft  <= walkMove < 0;
            movingRight <= walkMove > 0;
        end
    end

    assign state = '{
        xPos:        xPos,
        yPos:        yPos,
        airborne:    airborne,
        crouching:   crouching,
        facingLeft:  facingLeft,
        movingLeft:  movingLeft,
        movingRight: movingRight
    };

endmodule

//--- hw/jumpControl.sv
`timescale 1ns/1ps

module jumpControl #(
    parameter int JumpSpeed = 12
) (
    input  logic               Reset,
    input  logic               frame_clk,
    input  logic               playing,
    input  logic               jump,
    input  fighterPkg::coord_t yPos,
    output logic signed [7:0]  yMotion,
    output logic               airborne
);
    import fighterPkg::*;

    localparam logic signed [7:0] LaunchVel = 8'(-JumpSpeed); // Upward is negative Y

    logic signed [7:0]  velocity;
    logic signed [11:0] yProbe;    // Where yPos would end up this frame
    coord_t             toGround;
    logic               landing;

    assign yProbe   = $signed({2'b00, yPos}) + velocity;
    assign toGround = GroundY - yPos;
    assign landing  = airborne && (yProbe >= $signed({2'b00, GroundY}));

    // Step handed to the position register
    always_comb
    begin
        if (!airborne)
            yMotion = '0;
        else if (landing)
            yMotion = 8'(toGround); // Snap onto the floor
        else
            yMotion = velocity;
    end

    always_ff @(posedge Reset or posedge frame_clk)
    begin
        if (frame_clk)
        begin
            velocity <= '0;
            airborne <= 1'b0;
        end
        else if (playing)
        begin
            if (!airborne)
            begin
                if (jump)
                begin
                    velocity <= LaunchVel; // Takeoff
                    airborne <= 1'b1;
                end
            end
            else if (landing)
            begin
                velocity <= '0;
                airborne <= 1'b0;
            end
            else
            begin
                velocity <= velocity + 8'sd1; // Gravity
            end
        end
    end

endmodule

//--- hw/keyDecoder.sv
`timescale 1ns/1ps

module keyDecoder #(
    parameter fighterPkg::keyMap_t keyMap = fighterPkg::P1Keys
) (
    input  logic [7:0]                 keys [4],
    output fighterPkg::fighterAction_t action
);

    // True when any of the report slots carries this code
    function automatic logic isHeld(
        input logic [7:0] slots [4],
        input logic [7:0] code
    );
        logic hit;
        hit = 1'b0;
        for (int slot = 0; slot < 4; slot++)
        begin
            if (slots[slot] == code)
                hit = 1'b1;
        end
        return hit;
    endfunction

    // Every binding is checked on its own so chords register together.
    // Left plus right is passed on as is and sorted out in the motion block.
    always_comb
    begin
        action           = '0;
        action.walkLeft  = isHeld(keys, keyMap.left);
        action.walkRight = isHeld(keys, keyMap.right);
        action.crouch    = isHeld(keys, keyMap.down);
        action.jump      = isHeld(keys, keyMap.up);
        action.punch     = isHeld(keys, keyMap.punch);
    end

endmodule

//--- hw/fighterPkg.sv
package fighterPkg;

    // Screen coordinates in pixels
    localparam int CoordWidth = 10;

    typedef logic [CoordWidth-1:0] coord_t;

    // One player's decoded intent for the current frame
    typedef struct packed {
        logic walkLeft;
        logic walkRight;
        logic crouch;
        logic jump;
        logic punch;
    } fighterAction_t;

    // What a fighter shows to the rest of the game, 25 bits
    typedef struct packed {
        coord_t xPos;          // Left edge of the fighter box
        coord_t yPos;          // Top edge, GroundY when standing
        logic   airborne;
        logic   crouching;
        logic   facingLeft;
        logic   movingLeft;
        logic   movingRight;
    } fighterState_t;

    // One player's key binding as USB HID keycodes
    typedef struct packed {
        logic [7:0] left;
        logic [7:0] right;
        logic [7:0] down;
        logic [7:0] up;
        logic [7:0] punch;
    } keyMap_t;

    // A D S W F
    localparam keyMap_t P1Keys = '{
        left:  8'h04,
        right: 8'h07,
        down:  8'h16,
        up:    8'h1A,
        punch: 8'h09
    };

    // Arrow keys and M
    localparam keyMap_t P2Keys = '{
        left:  8'h50,
        right: 8'h4F,
        down:  8'h51,
        up:    8'h52,
        punch: 8'h10
    };

    localparam coord_t GroundY = coord_t'(215); // Standing Y for both fighters

endpackage
